/* Makefile */
# Verilator build and run of the DRAM DMA glue testbench

VERILATOR ?= verilator
TOP       ?= dram_dma_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Simulation finished: FAIL
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Test failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/dram_dma_tb.sv */
/*
  DRAM DMA glue testbench
  Directed tests of the reset tree, control word, debug ID mux,
  FLR response, DDR ready bits and statistics pipes
*/
module dram_dma_tb
  import dram_dma_pkg::*;
();

  // Cycle budget of all tests, the watchdog allows twice that
  localparam int test_cycles     = 1000;
  localparam int watchdog_cycles = 2 * test_cycles;

  logic                          clk;
  logic                          sync_rst_n;
  ctl_word_t                     ctl0;
  logic                          flr_assert;
  logic                          shell_ddr_ready;
  logic [2:0]                    lcl_ddr_ready;
  scrb_addr_t [num_ddr_chan-1:0] scrb_addr;
  logic [num_ddr_chan-1:0]       scrb_en;
  logic                          flr_done;
  logic [num_ddr_chan-1:0]       all_ddr_ready;
  id_word_t                      id0;
  id_word_t                      id1;
  stat_req_t [num_stat_chan-1:0] stat_req_in;
  stat_req_t [num_stat_chan-1:0] stat_req_out;
  stat_ack_t [num_stat_chan-1:0] stat_ack_in;
  stat_ack_t [num_stat_chan-1:0] stat_ack_out;

  int seed;
  int checks;
  int errors;

  tb_clk_gen #(.PERIOD(20)) u_clk_gen (.clk(clk));

  dram_dma_top dut0 (
    .clk             (clk),
    .sync_rst_n      (sync_rst_n),
    .ctl0            (ctl0),
    .flr_assert      (flr_assert),
    .shell_ddr_ready (shell_ddr_ready),
    .lcl_ddr_ready   (lcl_ddr_ready),
    .scrb_addr       (scrb_addr),
    .scrb_en         (scrb_en),
    .flr_done        (flr_done),
    .all_ddr_ready   (all_ddr_ready),
    .id0             (id0),
    .id1             (id1),
    .stat_req_in     (stat_req_in),
    .stat_req_out    (stat_req_out),
    .stat_ack_in     (stat_ack_in),
    .stat_ack_out    (stat_ack_out)
  );

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  // Moves to the drive point just after the next rising edge
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic check_value(input string test, input logic [127:0] exp,
                             input logic [127:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("mismatch %s: expected %0h, actual %0h", test, exp, act);
    end
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic test_reset_state();
    sync_rst_n = 1'b0;
    // Inputs held busy through reset
    ctl0        = '1;
    flr_assert  = 1'b1;
    stat_req_in = '1;
    stat_ack_in = '1;
    repeat (5) @(posedge clk);
    #2;
    sync_rst_n = 1'b1;
    // Two synchronizer clocks, then four branch pipe clocks
    repeat (6) step();
    check_value("reset scrb_en", 128'(4'h0), 128'(scrb_en));
    check_value("reset flr_done", 128'(1'b0), 128'(flr_done));
    check_value("reset id0", 128'(32'hF000_1D0F), 128'(id0));
    check_value("reset id1", 128'(32'h1D51_FEDC), 128'(id1));
    check_value("reset stat_req_out", 128'(0), 128'(stat_req_out));
    check_value("reset stat_ack_out", 128'(0), 128'(stat_ack_out));
    ctl0        = '0;
    flr_assert  = 1'b0;
    stat_req_in = '0;
    stat_ack_in = '0;
  endtask

  task automatic test_scrub_enable();
    ctl_word_t   prev;
    logic [31:0] rnd;
    prev = ctl0;
    for (int i = 0; i < 20; i++)
    begin
      step();
      check_value("scrub enable", 128'(prev.scrb_en), 128'(scrb_en));
      rnd  = $random(seed);
      ctl0 = ctl_word_t'(rnd);
      prev = ctl0;
    end
  endtask

  task automatic test_debug_id();
    scrb_addr_t exp_addr;
    int         idx;
    step();
    for (int i = 0; i < num_ddr_chan; i++)
      scrb_addr[i] = {$random(seed), $random(seed)};
    for (int sel = 0; sel < 8; sel++)
    begin
      ctl0         = '0;
      ctl0.dbg_en  = 1'b1;
      ctl0.dbg_sel = sel[2:0];
      // Codes 0 to 3 follow the address order A, B, D, C
      idx      = (sel < 4) ? sel : 0;
      exp_addr = scrb_addr[idx];
      step();
      step();
      check_value("debug id0", 128'(exp_addr[31:0]), 128'(id0));
      check_value("debug id1", 128'(exp_addr[63:32]), 128'(id1));
    end
    ctl0 = '0;
    step();
    step();
    check_value("debug off id0", 128'(32'hF000_1D0F), 128'(id0));
    check_value("debug off id1", 128'(32'h1D51_FEDC), 128'(id1));
  endtask

  task automatic test_flr();
    logic exp;
    step();
    check_value("flr idle", 128'(1'b0), 128'(flr_done));
    flr_assert = 1'b1;
    // High on every even cycle after assertion
    for (int j = 1; j <= 10; j++)
    begin
      step();
      exp = (j % 2 == 0);
      check_value("flr held", 128'(exp), 128'(flr_done));
    end
    flr_assert = 1'b0;
    for (int j = 1; j <= 8; j++)
    begin
      step();
      if (j >= 2)
        check_value("flr released", 128'(1'b0), 128'(flr_done));
    end
  endtask

  task automatic test_ddr_ready();
    logic       prev_shell;
    logic [3:0] exp;
    prev_shell = shell_ddr_ready;
    for (int combo = 0; combo < 16; combo++)
    begin
      step();
      {shell_ddr_ready, lcl_ddr_ready} = combo[3:0];
      #1;
      exp = {lcl_ddr_ready[2], prev_shell, lcl_ddr_ready[1:0]};
      check_value("ddr ready", 128'(exp), 128'(all_ddr_ready));
      prev_shell = shell_ddr_ready;
    end
  endtask

  task automatic test_stat_pipes();
    stat_req_t [num_stat_chan-1:0] req_hist [$];
    stat_ack_t [num_stat_chan-1:0] ack_hist [$];
    stat_req_t [num_stat_chan-1:0] req_now;
    stat_ack_t [num_stat_chan-1:0] ack_now;
    stat_req_t [num_stat_chan-1:0] req_exp;
    stat_ack_t [num_stat_chan-1:0] ack_exp;
    logic [31:0]                   hi;
    logic [31:0]                   lo;
    for (int i = 0; i < 40 + stat_pipe_stages; i++)
    begin
      step();
      if (i >= stat_pipe_stages)
      begin
        req_exp = req_hist.pop_front();
        ack_exp = ack_hist.pop_front();
        check_value("stat request", 128'(req_exp), 128'(stat_req_out));
        check_value("stat ack", 128'(ack_exp), 128'(stat_ack_out));
      end
      for (int ch = 0; ch < num_stat_chan; ch++)
      begin
        hi = $random(seed);
        lo = $random(seed);
        req_now[ch] = (i < 40) ? {hi[9:0], lo} : '0;
        hi = $random(seed);
        lo = $random(seed);
        ack_now[ch] = (i < 40) ? {hi[8:0], lo} : '0;
      end
      stat_req_in = req_now;
      stat_ack_in = ack_now;
      req_hist.push_back(req_now);
      ack_hist.push_back(ack_now);
    end
  endtask

  // ----------------------------------------
  // Sequence and watchdog
  // ----------------------------------------
  initial
  begin
    seed            = 32'he77b;
    checks          = 0;
    errors          = 0;
    sync_rst_n      = 1'b0;
    ctl0            = '0;
    flr_assert      = 1'b0;
    shell_ddr_ready = 1'b0;
    lcl_ddr_ready   = '0;
    scrb_addr       = '0;
    stat_req_in     = '0;
    stat_ack_in     = '0;
    test_reset_state();
    test_scrub_enable();
    test_debug_id();
    test_flr();
    test_ddr_ready();
    test_stat_pipes();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog timeout: tests did not finish within %0d cycles", watchdog_cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* dv/tb_clk_gen.sv */
/*
  Testbench clock source
  Free-running clock with a settable period
*/
module tb_clk_gen #(
  parameter int PERIOD = 20
) (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

/* logic/ctl_status.sv */
/*
  Control and status
  Registers the shell control word, decodes the scrub enables,
  drives the ID words, answers FLR and gathers the DDR ready bits
*/
module ctl_status
  import dram_dma_pkg::*;
(
  input  logic                          clk,
  input  logic                          ctl_rst_n,
  input  ctl_word_t                     ctl0,
  input  logic                          flr_assert,
  input  logic                          shell_ddr_ready,
  input  logic [2:0]                    lcl_ddr_ready,
  input  scrb_addr_t [num_ddr_chan-1:0] scrb_addr,
  output logic [num_ddr_chan-1:0]       scrb_en,
  output logic                          flr_done,
  output logic [num_ddr_chan-1:0]       all_ddr_ready,
  output id_word_t                      id0,
  output id_word_t                      id1
);

  ctl_word_t  ctl_q;
  logic       flr_assert_q;
  logic       shell_ddr_ready_q;
  scrb_addr_t dbg_addr;

  // ----------------------------------------
  // Input registers and FLR response
  // ----------------------------------------
  always_ff @(posedge clk or negedge ctl_rst_n)
  begin
    if (!ctl_rst_n)
    begin
      ctl_q             <= '0;
      flr_assert_q      <= 1'b0;
      shell_ddr_ready_q <= 1'b0;
      flr_done          <= 1'b0;
    end
    else
    begin
      ctl_q             <= ctl0;
      flr_assert_q      <= flr_assert;
      shell_ddr_ready_q <= shell_ddr_ready;
      // Toggles while FLR is held, so each high cycle is a fresh done pulse
      flr_done          <= flr_assert_q && !flr_done;
    end
  end

  // Enable bits are already in channel order A, B, D, C
  assign scrb_en = ctl_q.scrb_en;

  // ----------------------------------------
  // Debug ID mux
  // ----------------------------------------
  always_comb
  begin
    case (ctl_q.dbg_sel)
      dbg_sel_ddrb: dbg_addr = scrb_addr[dbg_sel_ddrb];
      dbg_sel_ddrd: dbg_addr = scrb_addr[dbg_sel_ddrd];
      dbg_sel_ddrc: dbg_addr = scrb_addr[dbg_sel_ddrc];
      // Code 0 and the unused codes 4 to 7 all show channel A
      default:      dbg_addr = scrb_addr[dbg_sel_ddra];
    endcase
  end

  // Second register stage, fed from the registered word
  always_ff @(posedge clk)
  begin
    if (ctl_q.dbg_en)
    begin
      id0 <= dbg_addr[31:0];
      id1 <= dbg_addr[63:32];
    end
    else
    begin
      id0 <= id0_default;
      id1 <= id1_default;
    end
  end

  // ----------------------------------------
  // DDR ready aggregation
  // ----------------------------------------

  // Shell channel sits in slot 2, the local channels around it
  assign all_ddr_ready = {lcl_ddr_ready[2], shell_ddr_ready_q, lcl_ddr_ready[1:0]};

endmodule

/* logic/dram_dma_pkg.sv */
/*
  DRAM DMA glue package
  Shared widths, pipeline depths, ID words and bundle types for the
  reset, control and DDR statistics logic of the card top level
*/
package dram_dma_pkg;

  // ----------------------------------------
  // Sizes and pipeline depths
  // ----------------------------------------
  localparam int num_ddr_chan     = 4;
  localparam int num_stat_chan    = 3;
  localparam int rst_pipe_stages  = 4;
  localparam int stat_pipe_stages = 8;

  // Shown on the ID outputs while debug is off
  localparam logic [31:0] id0_default = 32'hF000_1D0F;
  localparam logic [31:0] id1_default = 32'h1D51_FEDC;

  // Debug select codes
  // Each code is also the scrubber address index of its channel
  localparam logic [2:0] dbg_sel_ddra = 3'd0;
  localparam logic [2:0] dbg_sel_ddrb = 3'd1;
  localparam logic [2:0] dbg_sel_ddrd = 3'd2;
  localparam logic [2:0] dbg_sel_ddrc = 3'd3;

  // ----------------------------------------
  // Scalar types
  // ----------------------------------------
  typedef logic [31:0] id_word_t;
  typedef logic [63:0] scrb_addr_t;
  typedef logic [7:0]  stat_addr_t;
  typedef logic [31:0] stat_data_t;

  // ----------------------------------------
  // Bundles
  // ----------------------------------------

  // Shell control word 0
  // Scrub enable bits are A, B, D, C from bit 0 up
  typedef struct packed {
    logic        dbg_en;
    logic [2:0]  dbg_sel;
    logic [23:0] reserved;
    logic [3:0]  scrb_en;
  } ctl_word_t;

  // Statistics request toward the DDR side
  typedef struct packed {
    logic       wr;
    logic       rd;
    stat_addr_t addr;
    stat_data_t wdata;
  } stat_req_t;

  // Statistics acknowledge back to the shell
  typedef struct packed {
    logic       ack;
    logic [7:0] intr;
    stat_data_t rdata;
  } stat_ack_t;

endpackage

/* logic/dram_dma_top.sv */
/*
  DRAM DMA top level
  Joins the reset tree, the control block and the retiming
  pipes of the three DDR statistics channels
*/
module dram_dma_top
  import dram_dma_pkg::*;
(
  input  logic                          clk,
  input  logic                          sync_rst_n,
  input  ctl_word_t                     ctl0,
  input  logic                          flr_assert,
  input  logic                          shell_ddr_ready,
  input  logic [2:0]                    lcl_ddr_ready,
  input  scrb_addr_t [num_ddr_chan-1:0] scrb_addr,
  output logic [num_ddr_chan-1:0]       scrb_en,
  output logic                          flr_done,
  output logic [num_ddr_chan-1:0]       all_ddr_ready,
  output id_word_t                      id0,
  output id_word_t                      id1,
  input  stat_req_t [num_stat_chan-1:0] stat_req_in,
  output stat_req_t [num_stat_chan-1:0] stat_req_out,
  input  stat_ack_t [num_stat_chan-1:0] stat_ack_in,
  output stat_ack_t [num_stat_chan-1:0] stat_ack_out
);

  logic ctl_rst_n;
  logic stat_rst_n;

  // ----------------------------------------
  // Resets
  // ----------------------------------------
  reset_tree u_reset_tree (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .ctl_rst_n  (ctl_rst_n),
    .stat_rst_n (stat_rst_n)
  );

  // ----------------------------------------
  // Control and status
  // ----------------------------------------
  ctl_status u_ctl_status (
    .clk             (clk),
    .ctl_rst_n       (ctl_rst_n),
    .ctl0            (ctl0),
    .flr_assert      (flr_assert),
    .shell_ddr_ready (shell_ddr_ready),
    .lcl_ddr_ready   (lcl_ddr_ready),
    .scrb_addr       (scrb_addr),
    .scrb_en         (scrb_en),
    .flr_done        (flr_done),
    .all_ddr_ready   (all_ddr_ready),
    .id0             (id0),
    .id1             (id1)
  );

  // ----------------------------------------
  // Statistics retiming
  // ----------------------------------------

  // Requests go out toward the DDR side, acks come back to the shell
  for (genvar ch = 0; ch < num_stat_chan; ch++)
  begin : g_stat
    stage_pipe #(
      .WIDTH  ($bits(stat_req_t)),
      .STAGES (stat_pipe_stages)
    ) u_req_pipe (
      .clk     (clk),
      .rst_n   (stat_rst_n),
      .in_bus  (stat_req_in[ch]),
      .out_bus (stat_req_out[ch])
    );

    stage_pipe #(
      .WIDTH  ($bits(stat_ack_t)),
      .STAGES (stat_pipe_stages)
    ) u_ack_pipe (
      .clk     (clk),
      .rst_n   (stat_rst_n),
      .in_bus  (stat_ack_in[ch]),
      .out_bus (stat_ack_out[ch])
    );
  end

endmodule

/* logic/reset_tree.sv */
/*
  Reset tree
  Synchronizes the incoming reset and fans it out through
  per-block pipes, so each block gets its own local reset net
*/
module reset_tree
  import dram_dma_pkg::*;
(
  input  logic clk,
  input  logic sync_rst_n,
  output logic ctl_rst_n,
  output logic stat_rst_n
);

  logic                       core_pre_rst_n;
  logic                       core_rst_n;
  logic [rst_pipe_stages-1:0] ctl_pipe;
  logic [rst_pipe_stages-1:0] stat_pipe;

  // ----------------------------------------
  // Core synchronizer
  // ----------------------------------------

  // Asserts at once, releases after two clock edges
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      core_pre_rst_n <= 1'b0;
      core_rst_n     <= 1'b0;
    end
    else
    begin
      core_pre_rst_n <= 1'b1;
      core_rst_n     <= core_pre_rst_n;
    end
  end

  // ----------------------------------------
  // Branch pipes
  // ----------------------------------------

  // Plain shift registers, so branch assertion also lags the core
  always_ff @(posedge clk)
  begin
    ctl_pipe  <= {ctl_pipe[rst_pipe_stages-2:0], core_rst_n};
    stat_pipe <= {stat_pipe[rst_pipe_stages-2:0], core_rst_n};
  end

  assign ctl_rst_n  = ctl_pipe[rst_pipe_stages-1];
  assign stat_rst_n = stat_pipe[rst_pipe_stages-1];

endmodule

/* logic/stage_pipe.sv */
/*
  Stage pipe
  Delays a bundle of signals by a fixed number of registers
*/
module stage_pipe #(
  parameter int WIDTH  = 1,
  parameter int STAGES = 1
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [WIDTH-1:0] in_bus,
  output logic [WIDTH-1:0] out_bus
);

  logic [WIDTH-1:0] stage_q [STAGES];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < STAGES; i++)
        stage_q[i] <= '0;
    end
    else
    begin
      stage_q[0] <= in_bus;
      // Each stage takes the one before it
      for (int i = 1; i < STAGES; i++)
        stage_q[i] <= stage_q[i-1];
    end
  end

  assign out_bus = stage_q[STAGES-1];

endmodule

/* verilog.f */
logic/dram_dma_pkg.sv
logic/reset_tree.sv
logic/stage_pipe.sv
logic/ctl_status.sv
logic/dram_dma_top.sv
dv/tb_clk_gen.sv
dv/dram_dma_tb.sv
